// ==== rtl/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// core width, one word for data and addresses
`define CPU_XLEN     32

// architectural registers, x0 included
`define CPU_REGS     32

// first fetch after reset
`define CPU_RESET_PC 32'h0000_0000

// sequential pc step, one 32-bit instruction
`define CPU_PC_STEP  32'd4

// custom opcode that stops the core
`define CPU_HALT_OP  7'b111_1111

`endif

// ==== rtl/cpuTypesPkg.sv ====
`include "cpu_consts.svh"
`default_nettype none

package cpuTypesPkg;

  typedef logic [`CPU_XLEN-1:0] wordT;  // data or address word
  typedef logic [4:0]           regIdxT; // register index
  typedef logic [11:0]          immT;   // raw 12-bit immediate field

  typedef enum logic [6:0] {
    RTYPE    = 7'b0110011,
    ITYPE    = 7'b0010011,  // alu immediates only
    ITYPE_LW = 7'b0000011,
    JALR     = 7'b1100111,
    STYPE    = 7'b0100011,
    BTYPE    = 7'b1100011,
    JAL      = 7'b1101111,
    LUI      = 7'b0110111,
    AUIPC    = 7'b0010111,
    HALT     = `CPU_HALT_OP
  } opcodeT;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
  } aluOpT;

  // shared by R-type and I-type, funct7 picks the variant
  typedef enum logic [2:0] {
    ADD_SUB = 3'b000,
    SLL     = 3'b001,
    SLT     = 3'b010,
    SLTU    = 3'b011,
    XOR     = 3'b100,
    SRL_SRA = 3'b101,
    OR      = 3'b110,
    AND     = 3'b111
  } funct3T;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branchT;

  typedef enum logic [2:0] {
    RD_ALU, RD_LOAD, RD_LINK, RD_UPPER, RD_PCUPPER
  } rdSelT;

  typedef enum logic [1:0] {
    PC_SEQ, PC_BRANCHJUMP, PC_REGJUMP
  } pcSrcT;

  typedef enum logic [2:0] {
    PH_FETCH, PH_EXECUTE, PH_MEMORY, PH_WRITEBACK, PH_HALTED
  } phaseT;

endpackage

`default_nettype wire

// ==== rtl/controlUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlUnit import cpuTypesPkg::*; (
  input  wordT   instr,
  output regIdxT rs1,
  output regIdxT rs2,
  output regIdxT rd,
  output immT    imm,
  output aluOpT  aluOp,
  output logic   aluSrc,
  output logic   shift,
  output logic   regWr,
  output logic   dRen,
  output logic   dWen,
  output logic   jpSel,
  output logic   halt,
  output rdSelT  rdSel,
  output pcSrcT  pcSrc,
  output branchT branchKind
);

  opcodeT     opcode;
  funct3T     func3;
  logic [6:0] func7;

  always_comb
  begin
    // instruction fields
    opcode     = opcodeT'(instr[6:0]);
    rs1        = instr[19:15];
    rs2        = instr[24:20];
    rd         = instr[11:7];
    func3      = funct3T'(instr[14:12]);
    func7      = instr[31:25];
    imm        = instr[31:20];       // I-type layout unless a store
    branchKind = branchT'(instr[14:12]);

    // defaults, a no-op that steps the pc
    aluOp  = ALU_ADD;
    aluSrc = 1'b0;
    shift  = 1'b0;
    regWr  = 1'b0;
    dRen   = 1'b0;
    dWen   = 1'b0;
    jpSel  = 1'b0;
    halt   = 1'b0;
    rdSel  = RD_ALU;
    pcSrc  = PC_SEQ;

    case (opcode)
      RTYPE:
      begin
        regWr = 1'b1;               // rs1 op rs2 into rd
        case (func3)
          ADD_SUB: aluOp = (func7 == 7'b0100000) ? ALU_SUB : ALU_ADD;
          XOR:     aluOp = ALU_XOR;
          OR:      aluOp = ALU_OR;
          AND:     aluOp = ALU_AND;
          SLT:     aluOp = ALU_SLT;
          SLTU:    aluOp = ALU_SLTU;
          SLL:
          begin
            shift = 1'b1;           // shamt from rs2[4:0]
            aluOp = ALU_SLL;
          end
          SRL_SRA:
          begin
            shift = 1'b1;
            aluOp = (func7 == 7'b0100000) ? ALU_SRA : ALU_SRL;
          end
          default: aluOp = ALU_ADD;
        endcase
      end

      ITYPE:
      begin
        regWr  = 1'b1;
        aluSrc = 1'b1;              // sign extended imm as opB
        case (func3)
          ADD_SUB: aluOp = ALU_ADD; // addi has no subtract form
          XOR:     aluOp = ALU_XOR;
          OR:      aluOp = ALU_OR;
          AND:     aluOp = ALU_AND;
          SLT:     aluOp = ALU_SLT;
          SLTU:    aluOp = ALU_SLTU;
          SLL:
          begin
            shift = 1'b1;           // shamt in imm[4:0]
            aluOp = ALU_SLL;
          end
          SRL_SRA:
          begin
            shift = 1'b1;
            aluOp = (func7 == 7'b0100000) ? ALU_SRA : ALU_SRL;
          end
          default: aluOp = ALU_ADD;
        endcase
      end

      ITYPE_LW:
      begin
        regWr  = 1'b1;
        aluSrc = 1'b1;              // address = rs1 + imm
        dRen   = 1'b1;
        rdSel  = RD_LOAD;
      end

      STYPE:
      begin
        imm    = {instr[31:25], instr[11:7]}; // split store offset
        aluSrc = 1'b1;
        dWen   = 1'b1;              // rs2 goes out as store data
      end

      BTYPE:
      begin
        pcSrc = PC_BRANCHJUMP;      // core resolves taken or not
        case (branchKind)
          BEQ, BNE:   aluOp = ALU_SUB;  // zero flag decides
          BLT, BGE:   aluOp = ALU_SLT;
          BLTU, BGEU: aluOp = ALU_SLTU;
          default:    aluOp = ALU_SUB;
        endcase
      end

      JAL:
      begin
        regWr = 1'b1;
        rdSel = RD_LINK;            // pc + 4 into rd
        jpSel = 1'b1;               // always taken, J offset
        pcSrc = PC_BRANCHJUMP;
      end

      JALR:
      begin
        regWr  = 1'b1;
        aluSrc = 1'b1;              // target = rs1 + imm
        rdSel  = RD_LINK;
        pcSrc  = PC_REGJUMP;
      end

      LUI:
      begin
        regWr = 1'b1;
        rdSel = RD_UPPER;
      end

      AUIPC:
      begin
        regWr = 1'b1;
        rdSel = RD_PCUPPER;
      end

      HALT:    halt = 1'b1;
      default: halt = 1'b0;         // unknown opcode acts as a no-op
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu import cpuTypesPkg::*; (
  input  wordT  opA,
  input  wordT  opB,
  input  aluOpT aluOp,
  output wordT  result,
  output logic  zero
);

  logic [4:0] shamt;

  assign shamt = opB[4:0];          // rv32 shifts use five bits only

  always_comb
  begin
    case (aluOp)
      ALU_ADD:  result = opA + opB;
      ALU_SUB:  result = opA - opB;
      ALU_XOR:  result = opA ^ opB;
      ALU_OR:   result = opA | opB;
      ALU_AND:  result = opA & opB;
      ALU_SLL:  result = opA << shamt;
      ALU_SRL:  result = opA >> shamt;
      ALU_SRA:  result = wordT'($signed(opA) >>> shamt);
      ALU_SLT:  result = {31'b0, $signed(opA) < $signed(opB)};
      ALU_SLTU: result = {31'b0, opA < opB};
      default:  result = '0;
    endcase
  end

  // BEQ and BNE look at this after a subtract
  assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== rtl/registerFile.sv ====
`include "cpu_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module registerFile import cpuTypesPkg::*; (
  input  logic   CLK,
  input  logic   arstN,
  input  regIdxT rs1,
  input  regIdxT rs2,
  input  regIdxT rd,
  input  logic   wrEn,
  input  wordT   wrData,
  output wordT   rdData1,
  output wordT   rdData2
);

  wordT regs [1:`CPU_REGS-1];       // x0 has no storage

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 1; i < `CPU_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wrEn && (rd != '0))    // writes to x0 dropped
    begin
      regs[rd] <= wrData;
    end
  end

  assign rdData1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdData2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== rtl/fetchUnit.sv ====
`include "cpu_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module fetchUnit import cpuTypesPkg::*; (
  input  logic CLK,
  input  logic arstN,
  input  logic start,
  input  wordT nextPc,
  input  logic pcLoad,
  output wordT pc,
  output wordT instr,
  output logic instrValid,
  output wordT instrAdr,
  output logic instrCyc,
  output logic instrStb,
  input  wordT instrDat,
  input  logic instrAck
);

  logic ackSeen;

  assign ackSeen  = instrCyc & instrAck;  // ack only counts inside a cycle
  assign instrAdr = pc;                   // pc only moves in writeback, so it holds

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      pc <= `CPU_RESET_PC;
    end
    else if (pcLoad)
    begin
      pc <= nextPc;
    end
  end

  // one classic read per start
  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      instrCyc   <= 1'b0;
      instrStb   <= 1'b0;
      instrValid <= 1'b0;
    end
    else
    begin
      instrValid <= ackSeen;        // single-cycle pulse after ack
      if (ackSeen)
      begin
        instrCyc <= 1'b0;
        instrStb <= 1'b0;
      end
      else if (start)
      begin
        instrCyc <= 1'b1;
        instrStb <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (ackSeen)
    begin
      instr <= instrDat;            // held for decode until the next fetch
    end
  end

endmodule

`default_nettype wire

// ==== rtl/memAccess.sv ====
`timescale 1ns/1ps
`default_nettype none

module memAccess import cpuTypesPkg::*; (
  input  logic CLK,
  input  logic arstN,
  input  logic start,
  input  logic write,
  input  wordT addr,
  input  wordT storeData,
  output wordT loadData,
  output logic memDone,
  output wordT dataAdr,
  output wordT dataDatW,
  output logic dataWe,
  output logic dataCyc,
  output logic dataStb,
  input  wordT dataDatR,
  input  logic dataAck
);

  logic ackSeen;

  assign ackSeen = dataCyc & dataAck;
  assign memDone = ackSeen;         // done on the ack edge itself

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      dataCyc  <= 1'b0;
      dataStb  <= 1'b0;
      dataWe   <= 1'b0;
      dataAdr  <= '0;
      dataDatW <= '0;
    end
    else if (ackSeen)
    begin
      dataCyc <= 1'b0;              // drop right after ack
      dataStb <= 1'b0;
      dataWe  <= 1'b0;
    end
    else if (start)
    begin
      dataCyc  <= 1'b1;
      dataStb  <= 1'b1;
      dataWe   <= write;
      dataAdr  <= addr;             // captured once, steady until ack
      dataDatW <= storeData;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (ackSeen && !dataWe)
    begin
      loadData <= dataDatR;         // lw result for writeback
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cpuCore.sv ====
`include "cpu_consts.svh"
`timescale 1ns/1ps
`default_nettype none

module cpuCore import cpuTypesPkg::*; (
  input  logic CLK,
  input  logic arstN,
  output wordT instrAdr,
  output logic instrCyc,
  output logic instrStb,
  input  wordT instrDat,
  input  logic instrAck,
  output wordT dataAdr,
  output wordT dataDatW,
  output logic dataWe,
  output logic dataCyc,
  output logic dataStb,
  input  wordT dataDatR,
  input  logic dataAck,
  output logic halted
);

  phaseT  phase, phaseNext;
  wordT   pc, instr, nextPc, pcPlus4;
  logic   instrValid, fetchStart, memStart, memDone, pcLoad, wrEn;
  regIdxT rs1, rs2, rd;
  immT    imm;
  aluOpT  aluOp;
  logic   aluSrc, shift, regWr, dRen, dWen, jpSel, halt;
  rdSelT  rdSel;
  pcSrcT  pcSrc;
  branchT branchKind;
  wordT   rdData1, rdData2, opB, aluResult, loadData, wrData;
  wordT   immExt, branchOff, jumpOff, upperImm;
  logic   aluZero, branchTaken;

  assign fetchStart = (phase == PH_FETCH) && !instrCyc;  // first fetch cycle only
  assign memStart   = (phase == PH_EXECUTE) && instrValid && (dRen || dWen);
  assign pcLoad     = (phase == PH_WRITEBACK);
  assign wrEn       = (phase == PH_WRITEBACK) && regWr && (rd != '0);
  assign halted     = (phase == PH_HALTED);

  fetchUnit u_fetch (
    .CLK(CLK), .arstN(arstN), .start(fetchStart), .nextPc(nextPc), .pcLoad(pcLoad),
    .pc(pc), .instr(instr), .instrValid(instrValid),
    .instrAdr(instrAdr), .instrCyc(instrCyc), .instrStb(instrStb),
    .instrDat(instrDat), .instrAck(instrAck)
  );

  controlUnit u_ctrl (
    .instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .aluOp(aluOp),
    .aluSrc(aluSrc), .shift(shift), .regWr(regWr), .dRen(dRen), .dWen(dWen),
    .jpSel(jpSel), .halt(halt), .rdSel(rdSel), .pcSrc(pcSrc), .branchKind(branchKind)
  );

  registerFile u_regs (
    .CLK(CLK), .arstN(arstN), .rs1(rs1), .rs2(rs2), .rd(rd), .wrEn(wrEn),
    .wrData(wrData), .rdData1(rdData1), .rdData2(rdData2)
  );

  alu u_alu (
    .opA(rdData1), .opB(opB), .aluOp(aluOp), .result(aluResult), .zero(aluZero)
  );

  memAccess u_mem (
    .CLK(CLK), .arstN(arstN), .start(memStart), .write(dWen), .addr(aluResult),
    .storeData(rdData2), .loadData(loadData), .memDone(memDone),
    .dataAdr(dataAdr), .dataDatW(dataDatW), .dataWe(dataWe), .dataCyc(dataCyc),
    .dataStb(dataStb), .dataDatR(dataDatR), .dataAck(dataAck)
  );

  // immediates and offsets
  assign immExt    = {{(`CPU_XLEN-12){imm[11]}}, imm};
  assign branchOff = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign jumpOff   = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign upperImm  = {instr[31:12], 12'b0};
  assign pcPlus4   = pc + `CPU_PC_STEP;

  always_comb
  begin
    opB = aluSrc ? immExt : rdData2;
    if (shift)
    begin
      opB = {{(`CPU_XLEN-5){1'b0}}, opB[4:0]};  // shamt only
    end
  end

  always_comb
  begin
    case (branchKind)
      BEQ:        branchTaken = aluZero;
      BNE:        branchTaken = !aluZero;
      BLT, BLTU:  branchTaken = aluResult[0];   // slt/sltu gives 1 when less
      BGE, BGEU:  branchTaken = !aluResult[0];
      default:    branchTaken = 1'b0;
    endcase
  end

  always_comb
  begin
    case (pcSrc)
      PC_BRANCHJUMP: nextPc = jpSel       ? pc + jumpOff
                            : branchTaken ? pc + branchOff
                            : pcPlus4;
      PC_REGJUMP:    nextPc = {aluResult[`CPU_XLEN-1:1], 1'b0};  // jalr clears bit 0
      default:       nextPc = pcPlus4;
    endcase
  end

  always_comb
  begin
    case (rdSel)
      RD_LOAD:    wrData = loadData;
      RD_LINK:    wrData = pcPlus4;
      RD_UPPER:   wrData = upperImm;
      RD_PCUPPER: wrData = pc + upperImm;
      default:    wrData = aluResult;
    endcase
  end

  always_comb
  begin
    phaseNext = phase;
    case (phase)
      PH_FETCH:     if (instrCyc && instrAck) phaseNext = PH_EXECUTE;
      PH_EXECUTE:
      begin
        if (instrValid)
        begin
          if (halt)              phaseNext = PH_HALTED;
          else if (dRen || dWen) phaseNext = PH_MEMORY;
          else                   phaseNext = PH_WRITEBACK;
        end
      end
      PH_MEMORY:    if (memDone) phaseNext = PH_WRITEBACK;
      PH_WRITEBACK: phaseNext = PH_FETCH;
      default:      phaseNext = PH_HALTED;  // only reset leaves halt
    endcase
  end

  always_ff @(posedge CLK or negedge arstN)
  begin
    if (!arstN)
    begin
      phase <= PH_FETCH;
    end
    else
    begin
      phase <= phaseNext;
    end
  end

endmodule

`default_nettype wire

// ==== testbench/cpuCore_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCore_chk import cpuTypesPkg::*; (
  input logic CLK,
  input logic arstN,
  input wordT instrAdr,
  input logic instrCyc,
  input logic instrStb,
  input logic instrAck,
  input wordT dataAdr,
  input wordT dataDatW,
  input logic dataWe,
  input logic dataCyc,
  input logic dataStb,
  input logic dataAck,
  input logic halted
);

  int failCount = 0;                // failed assertions so far

  // request held until the classic ack
  instrHold: assert property (@(posedge CLK) disable iff (!arstN)
    instrStb && !instrAck |=> instrStb && $stable(instrAdr))
    else
    begin
      failCount++;
      $error("instr request changed or dropped before ack");
    end

  dataHold: assert property (@(posedge CLK) disable iff (!arstN)
    dataStb && !dataAck |=> dataStb && $stable(dataAdr) && $stable(dataWe) && $stable(dataDatW))
    else
    begin
      failCount++;
      $error("data request changed or dropped before ack");
    end

  instrDrop: assert property (@(posedge CLK) disable iff (!arstN)
    instrStb && instrAck |=> !instrStb)
    else
    begin
      failCount++;
      $error("instr stb still high after ack");
    end

  dataDrop: assert property (@(posedge CLK) disable iff (!arstN)
    dataStb && dataAck |=> !dataStb)
    else
    begin
      failCount++;
      $error("data stb still high after ack");
    end

  // a single instruction in flight keeps the buses apart
  oneBus: assert property (@(posedge CLK) disable iff (!arstN) !(instrStb && dataStb))
    else
    begin
      failCount++;
      $error("stb high on both buses at once");
    end

  resetQuiet: assert property (@(posedge CLK)
    !arstN |-> !instrCyc && !instrStb && !dataCyc && !dataStb)
    else
    begin
      failCount++;
      $error("bus cycle active during reset");
    end

  haltSticky: assert property (@(posedge CLK) disable iff (!arstN) halted |=> halted)
    else
    begin
      failCount++;
      $error("halted fell without reset");
    end

  haltQuiet: assert property (@(posedge CLK) disable iff (!arstN)
    halted |-> !instrStb && !dataStb)
    else
    begin
      failCount++;
      $error("bus cycle started while halted");
    end

endmodule

bind cpuCore cpuCore_chk u_chk (.*);

`default_nettype wire

// ==== testbench/cpuCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb import cpuTypesPkg::*;;

  localparam int   STORES       = 14;
  localparam int   HALT_TIMEOUT = 5000;   // cycles from reset release to halt
  localparam int   QUIET_CYCLES = 40;     // watch window after halt
  localparam wordT MARKER       = 32'h0000_05AD;
  localparam wordT TRAP         = 32'h0000_0200;

  logic CLK      = 1'b0;
  logic arstN    = 1'b1;
  wordT instrDat = '0;
  logic instrAck = 1'b0;
  wordT dataDatR = '0;
  logic dataAck  = 1'b0;
  wordT instrAdr, dataAdr, dataDatW;
  logic instrCyc, instrStb, dataWe, dataCyc, dataStb, halted;

  wordT        imem [256];
  wordT        dmem [256];
  logic [63:0] expStore [STORES];         // {address, data}
  logic [31:0] lfsr = 32'h5f7a;
  logic [1:0]  instrWait = 2'd0;
  logic [1:0]  dataWait  = 2'd1;
  wordT        pcAsm;
  int          storeIdx, storeErrors, otherErrors, cycles, total;

  cpuCore u_dut (.*);

  always #4 CLK = ~CLK;                   // 8 ns period

  function automatic logic takeBit();
    lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);  // galois step
    return lfsr[0];
  endfunction

  function automatic logic [1:0] drawWait();
    logic hi, lo;
    hi = takeBit();
    lo = takeBit();
    return {hi, lo};                      // 0 to 3 wait cycles
  endfunction

  function automatic wordT rInstr(input logic [6:0] f7, input logic [4:0] rs2,
                                  input logic [4:0] rs1, input logic [2:0] f3,
                                  input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic wordT iInstr(input logic [11:0] imm, input logic [4:0] rs1,
                                  input logic [2:0] f3, input logic [4:0] rd,
                                  input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic wordT swInstr(input logic [4:0] rs2, input logic [11:0] off);
    return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'h23};  // base is always x0
  endfunction

  function automatic wordT branchTo(input logic [2:0] f3, input logic [4:0] rs1,
                                    input logic [4:0] rs2, input wordT target);
    wordT off;
    off = target - pcAsm;
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic wordT jalTo(input logic [4:0] rd, input wordT target);
    wordT off;
    off = target - pcAsm;
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6F};
  endfunction

  task automatic emit(input wordT w);
    imem[pcAsm[9:2]] = w;
    pcAsm = pcAsm + 32'd4;
  endtask

  task automatic buildProgram();
    for (int i = 0; i < 256; i++)
    begin
      imem[i] = iInstr(12'(i), 5'd0, 3'b000, 5'd0, 7'h13);  // addi x0 no-op per slot
      dmem[i] = 32'hDA7A_0000 | (i << 2);
    end
    pcAsm = 32'h0;
    emit(iInstr(12'hFF9, 5'd0, 3'b000, 5'd1, 7'h13));   // x1 = -7
    emit(iInstr(12'd3, 5'd0, 3'b000, 5'd2, 7'h13));     // x2 = 3
    emit(rInstr(7'h20, 5'd2, 5'd1, 3'b000, 5'd3));      // sub
    emit(swInstr(5'd3, 12'h100));
    emit(rInstr(7'h20, 5'd2, 5'd1, 3'b101, 5'd4));      // sra
    emit(swInstr(5'd4, 12'h104));
    emit(rInstr(7'h00, 5'd2, 5'd1, 3'b010, 5'd5));      // slt
    emit(rInstr(7'h00, 5'd2, 5'd1, 3'b011, 5'd6));      // sltu
    emit(swInstr(5'd5, 12'h108));
    emit(swInstr(5'd6, 12'h10C));
    emit(iInstr(12'h0F0, 5'd1, 3'b100, 5'd7, 7'h13));   // xori
    emit(iInstr(12'd4, 5'd1, 3'b101, 5'd8, 7'h13));     // srli
    emit(swInstr(5'd7, 12'h110));
    emit(swInstr(5'd8, 12'h114));
    emit(rInstr(7'h00, 5'd7, 5'd2, 3'b110, 5'd9));      // or
    emit(swInstr(5'd9, 12'h118));
    emit(iInstr(12'h110, 5'd0, 3'b010, 5'd10, 7'h03));  // lw back the xori word
    emit(swInstr(5'd10, 12'h11C));
    emit(iInstr(12'd5, 5'd0, 3'b000, 5'd0, 7'h13));     // write attempt on x0
    emit(swInstr(5'd0, 12'h120));
    emit(iInstr(12'h5AD, 5'd0, 3'b000, 5'd31, 7'h13));  // marker value
    emit(branchTo(3'b000, 5'd2, 5'd2, pcAsm + 32'd8));  // each taken one skips a marker
    emit(swInstr(5'd31, 12'h1F0));
    emit(branchTo(3'b001, 5'd1, 5'd2, pcAsm + 32'd8));
    emit(swInstr(5'd31, 12'h1F0));
    emit(branchTo(3'b100, 5'd1, 5'd2, pcAsm + 32'd8));
    emit(swInstr(5'd31, 12'h1F0));
    emit(branchTo(3'b101, 5'd2, 5'd1, pcAsm + 32'd8));
    emit(swInstr(5'd31, 12'h1F0));
    emit(branchTo(3'b110, 5'd2, 5'd1, pcAsm + 32'd8));
    emit(swInstr(5'd31, 12'h1F0));
    emit(branchTo(3'b111, 5'd1, 5'd2, pcAsm + 32'd8));
    emit(swInstr(5'd31, 12'h1F0));
    emit(branchTo(3'b000, 5'd1, 5'd2, TRAP));           // not-taken ones aim at the trap
    emit(branchTo(3'b001, 5'd2, 5'd2, TRAP));
    emit(branchTo(3'b100, 5'd2, 5'd1, TRAP));
    emit(branchTo(3'b101, 5'd1, 5'd2, TRAP));
    emit(branchTo(3'b110, 5'd1, 5'd2, TRAP));
    emit(branchTo(3'b111, 5'd2, 5'd1, TRAP));
    emit(swInstr(5'd2, 12'h124));
    emit(jalTo(5'd11, pcAsm + 32'd8));                  // link 0xA4
    emit(swInstr(5'd31, 12'h1F0));
    emit(swInstr(5'd11, 12'h128));
    emit(iInstr(12'd189, 5'd0, 3'b000, 5'd12, 7'h13));  // odd target for jalr to round down
    emit(iInstr(12'd0, 5'd12, 3'b000, 5'd13, 7'h67));   // jalr with link 0xB4
    emit(swInstr(5'd31, 12'h1F0));
    emit(swInstr(5'd31, 12'h1F0));
    emit(swInstr(5'd13, 12'h12C));
    emit({20'hABCDE, 5'd14, 7'h37});                    // lui
    emit({20'h12345, 5'd15, 7'h17});                    // auipc at 0xC4
    emit(swInstr(5'd14, 12'h130));
    emit(swInstr(5'd15, 12'h134));
    emit(32'h0000_007F);                                // halt
    pcAsm = TRAP;
    emit(swInstr(5'd31, 12'h1F0));
    emit(32'h0000_007F);
  endtask

  task automatic loadExpected();
    expStore[0]  = {32'h100, 32'hFFFF_FFF6};  // -7 minus 3
    expStore[1]  = {32'h104, 32'hFFFF_FFFF};  // -7 >>> 3
    expStore[2]  = {32'h108, 32'h0000_0001};
    expStore[3]  = {32'h10C, 32'h0000_0000};
    expStore[4]  = {32'h110, 32'hFFFF_FF09};
    expStore[5]  = {32'h114, 32'h0FFF_FFFF};
    expStore[6]  = {32'h118, 32'hFFFF_FF0B};
    expStore[7]  = {32'h11C, 32'hFFFF_FF09};  // lw copy unchanged
    expStore[8]  = {32'h120, 32'h0000_0000};
    expStore[9]  = {32'h124, 32'h0000_0003};
    expStore[10] = {32'h128, 32'h0000_00A4};
    expStore[11] = {32'h12C, 32'h0000_00B4};
    expStore[12] = {32'h130, 32'hABCD_E000};
    expStore[13] = {32'h134, 32'h1234_50C4};
  endtask

  always @(posedge CLK)                   // instruction slave
  begin
    if (instrAck)
    begin
      instrAck  <= 1'b0;
      instrWait <= drawWait();
    end
    else if (instrCyc && instrStb)
    begin
      if (instrWait == 2'd0)
      begin
        instrAck <= 1'b1;
        instrDat <= imem[instrAdr[9:2]];
      end
      else
      begin
        instrWait <= instrWait - 2'd1;
      end
    end
  end

  always @(posedge CLK)                   // data slave
  begin
    if (dataAck)
    begin
      dataAck  <= 1'b0;
      dataWait <= drawWait();
    end
    else if (dataCyc && dataStb)
    begin
      if (dataWait == 2'd0)
      begin
        dataAck <= 1'b1;
        if (dataWe)
          dmem[dataAdr[9:2]] <= dataDatW;
        else
          dataDatR <= dmem[dataAdr[9:2]];
      end
      else
      begin
        dataWait <= dataWait - 2'd1;
      end
    end
  end

  always @(posedge CLK)                   // store checks on the write ack edge
  begin
    if (dataCyc && dataStb && dataWe && dataAck)
    begin
      assert (dataDatW != MARKER)
      else
      begin
        storeErrors++;
        $display("skipped instruction stored at %0t", $time);
      end
      assert (storeIdx < STORES)
      else
      begin
        storeErrors++;
        $display("extra store at %0t to address %h", $time, dataAdr);
      end
      if (storeIdx < STORES)
      begin
        assert (dataAdr == expStore[storeIdx][63:32])
        else
        begin
          storeErrors++;
          $display("[FAIL] %0t dataAdr got %h expected %h", $time, dataAdr,
                   expStore[storeIdx][63:32]);
        end
        assert (dataDatW == expStore[storeIdx][31:0])
        else
        begin
          storeErrors++;
          $display("[FAIL] %0t dataDatW got %h expected %h", $time, dataDatW,
                   expStore[storeIdx][31:0]);
        end
      end
      storeIdx++;
    end
  end

  initial
  begin
    arstN       <= 1'b0;                  // falling edge at time 0 clears the core
    storeIdx    = 0;
    storeErrors = 0;
    otherErrors = 0;
    buildProgram();
    loadExpected();
    repeat (10) @(posedge CLK);
    arstN <= 1'b1;
    cycles = 0;
    while (!halted && cycles < HALT_TIMEOUT)
    begin
      @(posedge CLK);
      cycles++;
    end
    if (!halted)
    begin
      otherErrors++;
      $display("timeout, core never reached halt");
    end
    else
    begin
      for (cycles = 0; cycles < QUIET_CYCLES; cycles++)  // halt holds and both buses stay idle
      begin
        @(posedge CLK);
        assert (halted)
        else
        begin
          otherErrors++;
          $display("[FAIL] %0t halted got %b expected 1", $time, halted);
        end
        assert (!instrStb && !dataStb)
        else
        begin
          otherErrors++;
          $display("bus strobe raised after halt at %0t", $time);
        end
      end
    end
    assert (storeIdx == STORES)
    else
    begin
      otherErrors++;
      $display("saw %0d stores, the program makes %0d", storeIdx, STORES);
    end
    total = storeErrors + otherErrors + u_dut.u_chk.failCount;
    $display("stores %0d, store errors %0d, other errors %0d, assertion errors %0d",
             storeIdx, storeErrors, otherErrors, u_dut.u_chk.failCount);
    if (total == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+rtl
rtl/cpuTypesPkg.sv
rtl/controlUnit.sv
rtl/alu.sv
rtl/registerFile.sv
rtl/fetchUnit.sv
rtl/memAccess.sv
rtl/cpuCore.sv
testbench/cpuCore_chk.sv
testbench/cpuCoreTb.sv
